//--- dcache_top.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_way.sv
logic/dcache_hit_select.sv
logic/dcache_line_mover.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
test/tb_clock.sv
test/tb_dcache.sv

//--- logic/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

//////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////

`define DC_ADDR_W       32
`define DC_WORD_BYTES   8

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

`define DC_LINE_BYTES   32
`define DC_SETS         8
`define DC_WAYS         2

// one burst moves a whole line
`define DC_BEATS        (`DC_LINE_BYTES / `DC_WORD_BYTES)

`endif

//--- logic/dcache_ctrl.sv
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                  I_clk,
    input  logic                  I_rst,
    input  dcache_pkg::cpu_op_e   cpu_op,
    input  dcache_pkg::addr_t     cpu_addr,
    input  dcache_pkg::word_t     cpu_wdata,
    input  dcache_pkg::strb_t     cpu_wstrb,
    output logic                  cpu_ready,
    output logic                  cpu_rvalid,
    output dcache_pkg::word_t     cpu_rdata,
    output logic                  cpu_bvalid,
    input  logic                  any_hit,
    input  dcache_pkg::way_t      hit_way,
    input  dcache_pkg::way_t      victim_way,
    input  logic                  victim_dirty,
    input  dcache_pkg::word_t     read_word,
    output dcache_pkg::index_t    index,
    output dcache_pkg::tag_t      lookup_tag,
    output dcache_pkg::word_sel_t word_sel,
    output logic [`DC_WAYS-1:0]   fill_en,
    output logic [`DC_WAYS-1:0]   word_en,
    output dcache_pkg::word_t     word_data,
    output dcache_pkg::strb_t     word_strb,
    output logic                  refill_start,
    output logic                  evict_start,
    input  logic                  refill_done,
    input  logic                  evict_done
);
    import dcache_pkg::*;

    localparam int WORD_OFF_W = $clog2(`DC_WORD_BYTES);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    cpu_op_e     req_op;
    tag_t        req_tag;
    index_t      req_index;
    word_sel_t   req_sel;
    word_t       req_wdata;
    strb_t       req_wstrb;
    way_t        victim_q;
    logic        accept;
    logic        lookup_hit;

    assign cpu_ready    = (state == ST_IDLE);
    assign accept       = cpu_ready && (cpu_op != OP_NONE);
    assign lookup_hit   = (state == ST_LOOKUP) && any_hit;
    assign cpu_rvalid   = lookup_hit && (req_op == OP_READ);
    assign cpu_bvalid   = lookup_hit && (req_op == OP_WRITE);
    assign cpu_rdata    = read_word;
    assign refill_start = (state == ST_LOOKUP) && !any_hit;
    assign evict_start  = (state == ST_REFILL) && refill_done && victim_dirty;

    // the held request addresses the ways for the whole miss
    assign index      = req_index;
    assign lookup_tag = req_tag;
    assign word_sel   = req_sel;
    assign word_data  = req_wdata;
    assign word_strb  = req_wstrb;

    always_comb begin
        fill_en = '0;
        word_en = '0;
        if (state == ST_ALLOCATE) fill_en[victim_q] = 1'b1;
        if (cpu_bvalid) word_en[hit_way] = 1'b1;
    end

    always_ff @(posedge I_clk) begin
        if (accept) begin
            {req_tag, req_index, req_sel} <= cpu_addr[`DC_ADDR_W-1:WORD_OFF_W];
            req_wdata <= cpu_wdata;
            req_wstrb <= cpu_wstrb;
        end
    end

    //////////////////////////////////////////////////
    // request fsm
    //////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state    <= ST_IDLE;
            req_op   <= OP_NONE;
            victim_q <= '0;
        end else begin
            state <= state_nxt;
            if (accept) req_op <= cpu_op;
            // victim fixed at the miss, the set does not change until install
            if (refill_start) victim_q <= victim_way;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (accept) state_nxt = ST_LOOKUP;
            ST_LOOKUP: state_nxt = any_hit ? ST_IDLE : ST_REFILL;
            ST_REFILL: begin
                if (refill_done) begin
                    state_nxt = victim_dirty ? ST_EVICT : ST_ALLOCATE;
                end
            end
            ST_EVICT: if (evict_done) state_nxt = ST_ALLOCATE;
            // lookup again, now a hit
            ST_ALLOCATE: state_nxt = ST_LOOKUP;
            default: state_nxt = ST_IDLE;
        endcase
    end

endmodule

//--- logic/dcache_hit_select.sv
`include "dcache_cfg.svh"

module dcache_hit_select (
    input  logic [`DC_WAYS-1:0]   way_hit,
    input  logic [`DC_WAYS-1:0]   way_valid,
    input  logic [`DC_WAYS-1:0]   way_dirty,
    input  dcache_pkg::tag_t      way_tag  [`DC_WAYS],
    input  dcache_pkg::line_t     way_line [`DC_WAYS],
    input  dcache_pkg::word_sel_t word_sel,
    output logic                  any_hit,
    output dcache_pkg::way_t      hit_way,
    output dcache_pkg::way_t      victim_way,
    output logic                  victim_dirty,
    output dcache_pkg::tag_t      victim_tag,
    output dcache_pkg::line_t     victim_line,
    output dcache_pkg::word_t     read_word
);
    import dcache_pkg::*;

    localparam int BEAT_W = `DC_WORD_BYTES * 8;

    assign any_hit = |way_hit;

    // downward scan so the lowest matching way wins
    always_comb begin
        hit_way    = '0;
        victim_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
            if (!way_valid[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    // victim view, feeds the writeback burst
    assign victim_dirty = way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];
    assign victim_line  = way_line[victim_way];

    assign read_word = way_line[hit_way][word_sel*BEAT_W +: BEAT_W];

    // a line is never installed in two ways of one set
    always_comb begin
        assert final ($isunknown(way_hit) || $onehot0(way_hit))
            else $error("hit_select: more than one way hits");
    end

endmodule

//--- logic/dcache_line_mover.sv
`include "dcache_cfg.svh"

module dcache_line_mover (
    input  logic               I_clk,
    input  logic               I_rst,
    input  logic               refill_start,
    input  logic               evict_start,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   refill_tag,
    input  dcache_pkg::tag_t   victim_tag,
    input  dcache_pkg::line_t  victim_line,
    output logic               refill_done,
    output logic               evict_done,
    output dcache_pkg::line_t  fill_line,
    output dcache_pkg::addr_t  mem_araddr,
    output logic               mem_arvalid,
    input  logic               mem_arready,
    input  dcache_pkg::word_t  mem_rdata,
    input  logic               mem_rvalid,
    input  logic               mem_rlast,
    output dcache_pkg::addr_t  mem_awaddr,
    output logic               mem_awvalid,
    input  logic               mem_awready,
    output dcache_pkg::word_t  mem_wdata,
    output logic               mem_wvalid,
    output logic               mem_wlast,
    input  logic               mem_wready,
    input  logic               mem_bvalid
);
    import dcache_pkg::*;

    localparam int LINE_OFF_W = $clog2(`DC_LINE_BYTES);
    localparam int BEAT_W     = `DC_WORD_BYTES * 8;

    mover_state_e state;
    word_sel_t    beat_cnt;
    line_t        line_buf;
    logic         w_fire;

    //////////////////////////////////////////////////
    // channel outputs
    //////////////////////////////////////////////////

    // line aligned, tag and index are held by the ctrl
    assign mem_araddr  = {refill_tag, index, {LINE_OFF_W{1'b0}}};
    assign mem_awaddr  = {victim_tag, index, {LINE_OFF_W{1'b0}}};
    assign mem_arvalid = (state == MV_AR);
    assign mem_awvalid = (state == MV_AW);
    assign mem_wvalid  = (state == MV_W);
    assign mem_wdata   = victim_line[beat_cnt*BEAT_W +: BEAT_W];
    assign mem_wlast   = mem_wvalid && (beat_cnt == word_sel_t'(`DC_BEATS - 1));
    assign w_fire      = mem_wvalid && mem_wready;
    assign evict_done  = (state == MV_B) && mem_bvalid;
    assign fill_line   = line_buf;

    //////////////////////////////////////////////////
    // burst fsm
    //////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state       <= MV_IDLE;
            beat_cnt    <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= (state == MV_R) && mem_rvalid && mem_rlast;
            case (state)
                MV_IDLE: begin
                    if (refill_start) begin
                        state <= MV_AR;
                    end else if (evict_start) begin
                        state <= MV_AW;
                    end
                end
                MV_AR: if (mem_arready) state <= MV_R;
                MV_R: if (mem_rvalid && mem_rlast) state <= MV_IDLE;
                MV_AW: begin
                    if (mem_awready) begin
                        state    <= MV_W;
                        beat_cnt <= '0;
                    end
                end
                MV_W: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (mem_wlast) state <= MV_B;
                    end
                end
                MV_B: if (mem_bvalid) state <= MV_IDLE;
                default: state <= MV_IDLE;
            endcase
        end
    end

    // read beats shift in from the top, word 0 ends lowest
    always_ff @(posedge I_clk) begin
        if ((state == MV_R) && mem_rvalid) begin
            line_buf <= {mem_rdata, line_buf[$bits(line_t)-1:BEAT_W]};
        end
    end

    assert property (@(posedge I_clk) disable iff (I_rst) refill_start |-> state == MV_IDLE)
        else $error("line_mover: refill requested while a burst is running");

endmodule

//--- logic/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    // address and data words
    typedef logic [`DC_ADDR_W-1:0]          addr_t;
    typedef logic [`DC_WORD_BYTES*8-1:0]    word_t;
    typedef logic [`DC_WORD_BYTES-1:0]      strb_t;
    typedef logic [`DC_LINE_BYTES*8-1:0]    line_t;

    // address split: tag | index | word select | byte
    typedef logic [`DC_ADDR_W-$clog2(`DC_SETS)-$clog2(`DC_LINE_BYTES)-1:0] tag_t;
    typedef logic [$clog2(`DC_SETS)-1:0]    index_t;
    typedef logic [$clog2(`DC_BEATS)-1:0]   word_sel_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]    way_t;

    typedef enum logic [1:0] {OP_NONE, OP_READ, OP_WRITE} cpu_op_e;

    // request sequencing
    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_REFILL, ST_EVICT, ST_ALLOCATE
    } ctrl_state_e;

    // burst engine
    typedef enum logic [2:0] {
        MV_IDLE, MV_AR, MV_R, MV_AW, MV_W, MV_B
    } mover_state_e;

endpackage

//--- logic/dcache_top.sv
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                I_clk,
    input  logic                I_rst,
    input  dcache_pkg::cpu_op_e cpu_op,
    input  dcache_pkg::addr_t   cpu_addr,
    input  dcache_pkg::word_t   cpu_wdata,
    input  dcache_pkg::strb_t   cpu_wstrb,
    output logic                cpu_ready,
    output logic                cpu_rvalid,
    output dcache_pkg::word_t   cpu_rdata,
    output logic                cpu_bvalid,
    output dcache_pkg::addr_t   mem_araddr,
    output logic                mem_arvalid,
    input  logic                mem_arready,
    input  dcache_pkg::word_t   mem_rdata,
    input  logic                mem_rvalid,
    input  logic                mem_rlast,
    output dcache_pkg::addr_t   mem_awaddr,
    output logic                mem_awvalid,
    input  logic                mem_awready,
    output dcache_pkg::word_t   mem_wdata,
    output logic                mem_wvalid,
    output logic                mem_wlast,
    input  logic                mem_wready,
    input  logic                mem_bvalid
);

    //////////////////////////////////////////////////
    // wires
    //////////////////////////////////////////////////

    dcache_pkg::index_t    index;
    dcache_pkg::tag_t      lookup_tag;
    dcache_pkg::word_sel_t word_sel;
    dcache_pkg::word_t     word_data;
    dcache_pkg::strb_t     word_strb;
    logic [`DC_WAYS-1:0]   fill_en;
    logic [`DC_WAYS-1:0]   word_en;
    dcache_pkg::line_t     fill_line;

    // per way results
    logic [`DC_WAYS-1:0]   way_hit;
    logic [`DC_WAYS-1:0]   way_valid;
    logic [`DC_WAYS-1:0]   way_dirty;
    dcache_pkg::tag_t      way_tag  [`DC_WAYS];
    dcache_pkg::line_t     way_line [`DC_WAYS];

    logic                  any_hit;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::way_t      victim_way;
    logic                  victim_dirty;
    dcache_pkg::tag_t      victim_tag;
    dcache_pkg::line_t     victim_line;
    dcache_pkg::word_t     read_word;
    logic                  refill_start;
    logic                  evict_start;
    logic                  refill_done;
    logic                  evict_done;

    //////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////

    dcache_ctrl u_ctrl (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_op       (cpu_op),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_wstrb    (cpu_wstrb),
        .cpu_ready    (cpu_ready),
        .cpu_rvalid   (cpu_rvalid),
        .cpu_rdata    (cpu_rdata),
        .cpu_bvalid   (cpu_bvalid),
        .any_hit      (any_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .read_word    (read_word),
        .index        (index),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .fill_en      (fill_en),
        .word_en      (word_en),
        .word_data    (word_data),
        .word_strb    (word_strb),
        .refill_start (refill_start),
        .evict_start  (evict_start),
        .refill_done  (refill_done),
        .evict_done   (evict_done)
    );

    // fill tag is the missing request's tag
    generate
        for (genvar g = 0; g < `DC_WAYS; g++) begin : g_way
            dcache_way u_way (
                .I_clk      (I_clk),
                .I_rst      (I_rst),
                .index      (index),
                .lookup_tag (lookup_tag),
                .fill_en    (fill_en[g]),
                .fill_tag   (lookup_tag),
                .fill_line  (fill_line),
                .word_en    (word_en[g]),
                .word_sel   (word_sel),
                .word_data  (word_data),
                .word_strb  (word_strb),
                .hit        (way_hit[g]),
                .valid      (way_valid[g]),
                .dirty      (way_dirty[g]),
                .tag        (way_tag[g]),
                .line       (way_line[g])
            );
        end
    endgenerate

    dcache_hit_select u_hit_select (
        .way_hit      (way_hit),
        .way_valid    (way_valid),
        .way_dirty    (way_dirty),
        .way_tag      (way_tag),
        .way_line     (way_line),
        .word_sel     (word_sel),
        .any_hit      (any_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .read_word    (read_word)
    );

    dcache_line_mover u_line_mover (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .refill_start (refill_start),
        .evict_start  (evict_start),
        .index        (index),
        .refill_tag   (lookup_tag),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .refill_done  (refill_done),
        .evict_done   (evict_done),
        .fill_line    (fill_line),
        .mem_araddr   (mem_araddr),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_rdata    (mem_rdata),
        .mem_rvalid   (mem_rvalid),
        .mem_rlast    (mem_rlast),
        .mem_awaddr   (mem_awaddr),
        .mem_awvalid  (mem_awvalid),
        .mem_awready  (mem_awready),
        .mem_wdata    (mem_wdata),
        .mem_wvalid   (mem_wvalid),
        .mem_wlast    (mem_wlast),
        .mem_wready   (mem_wready),
        .mem_bvalid   (mem_bvalid)
    );

endmodule

//--- logic/dcache_way.sv
`include "dcache_cfg.svh"

module dcache_way (
    input  logic                  I_clk,
    input  logic                  I_rst,
    input  dcache_pkg::index_t    index,
    input  dcache_pkg::tag_t      lookup_tag,
    input  logic                  fill_en,
    input  dcache_pkg::tag_t      fill_tag,
    input  dcache_pkg::line_t     fill_line,
    input  logic                  word_en,
    input  dcache_pkg::word_sel_t word_sel,
    input  dcache_pkg::word_t     word_data,
    input  dcache_pkg::strb_t     word_strb,
    output logic                  hit,
    output logic                  valid,
    output logic                  dirty,
    output dcache_pkg::tag_t      tag,
    output dcache_pkg::line_t     line
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0] valid_bits;
    logic [`DC_SETS-1:0] dirty_bits;
    tag_t                tag_mem  [`DC_SETS];
    line_t               line_mem [`DC_SETS];
    line_t               merged;

    // lookup is purely combinational on the index
    assign valid = valid_bits[index];
    assign dirty = dirty_bits[index];
    assign tag   = tag_mem[index];
    assign line  = line_mem[index];
    assign hit   = valid && (tag == lookup_tag);

    // byte merge of the cpu word into the selected line
    always_comb begin
        merged = line_mem[index];
        for (int b = 0; b < `DC_WORD_BYTES; b++) begin
            if (word_strb[b]) begin
                merged[(word_sel * `DC_WORD_BYTES + b) * 8 +: 8] = word_data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_en) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
        end else if (word_en) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge I_clk) begin
        if (fill_en) begin
            tag_mem[index]  <= fill_tag;
            line_mem[index] <= fill_line;
        end else if (word_en) begin
            line_mem[index] <= merged;
        end
    end

    // install and cpu write come from different fsm states
    assert property (@(posedge I_clk) disable iff (I_rst) !(fill_en && word_en))
        else $error("way: fill and word write in the same cycle");

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f dcache_top.f --top-module tb_dcache -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dcache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- test/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- test/tb_dcache.sv
`include "dcache_cfg.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int NUM_ROWS      = 17;
    localparam int RESP_LIMIT    = 80;
    localparam int CLK_PERIOD    = 100;
    localparam int WATCHDOG_TIME = NUM_ROWS * RESP_LIMIT * CLK_PERIOD;
    localparam int MEM_IDX_W     = 10;
    localparam int MEM_WORDS     = 1 << MEM_IDX_W;
    localparam int WORD_OFF_W    = $clog2(`DC_WORD_BYTES);

    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

    logic    I_clk;
    logic    I_rst;
    cpu_op_e cpu_op;
    addr_t   cpu_addr;
    word_t   cpu_wdata;
    strb_t   cpu_wstrb;
    logic    cpu_ready;
    logic    cpu_rvalid;
    word_t   cpu_rdata;
    logic    cpu_bvalid;

    addr_t   mem_araddr;
    logic    mem_arvalid;
    logic    mem_arready = 1'b0;
    word_t   mem_rdata   = '0;
    logic    mem_rvalid  = 1'b0;
    logic    mem_rlast   = 1'b0;
    addr_t   mem_awaddr;
    logic    mem_awvalid;
    logic    mem_awready = 1'b0;
    word_t   mem_wdata;
    logic    mem_wvalid;
    logic    mem_wlast;
    logic    mem_wready  = 1'b0;
    logic    mem_bvalid  = 1'b0;

    integer  seed   = 32'ha8bb3d14;

    // backing follows the bus, shadow follows the cpu
    word_t   backing [MEM_WORDS];
    word_t   shadow  [MEM_WORDS];

    // burst bookkeeping of the memory model
    int       rd_bursts   = 0;
    int       wb_bursts   = 0;
    int       wb_beats    = 0;
    addr_t    last_araddr = '0;
    addr_t    last_awaddr = '0;
    mem_idx_t rd_ptr      = '0;
    int       rd_beat     = 0;
    mem_idx_t wr_ptr      = '0;
    int       wr_beat     = 0;

    // stimulus table
    string   row_name   [NUM_ROWS];
    cpu_op_e row_op     [NUM_ROWS];
    addr_t   row_addr   [NUM_ROWS];
    word_t   row_wdata  [NUM_ROWS];
    strb_t   row_strb   [NUM_ROWS];
    int      row_reads  [NUM_ROWS];
    int      row_wbs    [NUM_ROWS];
    addr_t   row_wbaddr [NUM_ROWS];

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(I_clk));

    dcache_top u_dut (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_op      (cpu_op),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_wstrb   (cpu_wstrb),
        .cpu_ready   (cpu_ready),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_rdata   (cpu_rdata),
        .cpu_bvalid  (cpu_bvalid),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast),
        .mem_awaddr  (mem_awaddr),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wdata   (mem_wdata),
        .mem_wvalid  (mem_wvalid),
        .mem_wlast   (mem_wlast),
        .mem_wready  (mem_wready),
        .mem_bvalid  (mem_bvalid)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic word_t fill_pattern(input addr_t a);
        return {a ^ 32'h3c5a_96f0, ~a};
    endfunction

    function automatic mem_idx_t word_index(input addr_t a);
        return a[WORD_OFF_W +: MEM_IDX_W];
    endfunction

    // strobed bytes replace the old ones
    function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < `DC_WORD_BYTES; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic random_ready();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            fail_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    always @(posedge I_clk) begin
        if (I_rst) begin
            mem_arready <= 1'b0;
            mem_awready <= 1'b0;
            mem_wready  <= 1'b0;
            mem_rvalid  <= 1'b0;
            mem_rlast   <= 1'b0;
            mem_bvalid  <= 1'b0;
            rd_bursts   <= 0;
            wb_bursts   <= 0;
            wb_beats    <= 0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                backing[mem_idx_t'(i)] <= fill_pattern(addr_t'(i * `DC_WORD_BYTES));
            end
        end else begin
            // back-pressure on the address and write data channels
            mem_arready <= random_ready();
            mem_awready <= random_ready();
            mem_wready  <= random_ready();

            if (mem_arvalid && mem_arready) begin
                if (mem_araddr[$clog2(`DC_LINE_BYTES)-1:0] != '0) begin
                    fail_run("read burst address is not line aligned");
                end
                rd_bursts   <= rd_bursts + 1;
                last_araddr <= mem_araddr;
                rd_ptr      <= word_index(mem_araddr);
                rd_beat     <= 0;
                mem_rvalid  <= 1'b1;
                mem_rlast   <= 1'b0;
                mem_rdata   <= backing[word_index(mem_araddr)];
            end else if (mem_rvalid) begin
                if (mem_rlast) begin
                    mem_rvalid <= 1'b0;
                    mem_rlast  <= 1'b0;
                end else begin
                    rd_ptr    <= rd_ptr + 10'd1;
                    rd_beat   <= rd_beat + 1;
                    mem_rdata <= backing[rd_ptr + 10'd1];
                    mem_rlast <= (rd_beat == `DC_BEATS - 2);
                end
            end

            if (mem_awvalid && mem_awready) begin
                wb_bursts   <= wb_bursts + 1;
                last_awaddr <= mem_awaddr;
                wr_ptr      <= word_index(mem_awaddr);
                wr_beat     <= 0;
            end

            if (mem_wvalid && mem_wready) begin
                if (mem_wlast != (wr_beat == `DC_BEATS - 1)) begin
                    fail_run("wlast does not mark the fourth write beat");
                end
                backing[wr_ptr] <= mem_wdata;
                wr_ptr          <= wr_ptr + 10'd1;
                wr_beat         <= wr_beat + 1;
                wb_beats        <= wb_beats + 1;
                mem_bvalid      <= mem_wlast;
            end else begin
                mem_bvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus table and row runner
    //////////////////////////////////////////////////

    task automatic set_row(input int i, input string name, input cpu_op_e op, input addr_t addr,
                           input word_t wdata, input strb_t strb, input int reads,
                           input int wbs, input addr_t wb_addr);
        row_name[i]   = name;
        row_op[i]     = op;
        row_addr[i]   = addr;
        row_wdata[i]  = wdata;
        row_strb[i]   = strb;
        row_reads[i]  = reads;
        row_wbs[i]    = wbs;
        row_wbaddr[i] = wb_addr;
    endtask

    // set 0 fills both ways, then a third tag evicts way 0
    task automatic load_table();
        set_row(0, "cold_read", OP_READ, 32'h008, '0, '0, 1, 0, '0);
        set_row(1, "repeat_read", OP_READ, 32'h010, '0, '0, 0, 0, '0);
        set_row(2, "write_hit", OP_WRITE, 32'h008, 64'h1122_3344_5566_7788, 8'h0f, 0, 0, '0);
        set_row(3, "read_merged", OP_READ, 32'h008, '0, '0, 0, 0, '0);
        set_row(4, "fill_way1", OP_READ, 32'h100, '0, '0, 1, 0, '0);
        set_row(5, "evict_dirty", OP_READ, 32'h200, '0, '0, 1, 1, 32'h000);
        set_row(6, "reread_evicted", OP_READ, 32'h008, '0, '0, 1, 0, '0);
        set_row(7, "write_miss", OP_WRITE, 32'h058, 64'hcafe_f00d_dead_beef, 8'hf0, 1, 0, '0);
        set_row(8, "read_write_miss", OP_READ, 32'h058, '0, '0, 0, 0, '0);
        set_row(9, "write_way1", OP_WRITE, 32'h118, 64'ha5a5_5a5a_0f0f_f0f0, 8'h81, 0, 0, '0);
        set_row(10, "evict_clean", OP_READ, 32'h300, '0, '0, 1, 0, '0);
        set_row(11, "write_full", OP_WRITE, 32'h300, 64'h0f1e_2d3c_4b5a_6978, 8'hff, 0, 0, '0);
        set_row(12, "evict_full", OP_READ, 32'h400, '0, '0, 1, 1, 32'h300);
        set_row(13, "reread_full", OP_READ, 32'h300, '0, '0, 1, 0, '0);
        set_row(14, "read_way1", OP_READ, 32'h118, '0, '0, 0, 0, '0);
        set_row(15, "write_set7", OP_WRITE, 32'h2e8, 64'h7777_6666_5555_4444, 8'h3c, 1, 0, '0);
        set_row(16, "read_set7", OP_READ, 32'h2e8, '0, '0, 0, 0, '0);
    endtask

    task automatic run_row(input int r);
        int       lat;
        int       waited;
        int       rd0;
        int       wb0;
        int       beats0;
        bit       got;
        mem_idx_t idx;
        idx = word_index(row_addr[r]);
        @(posedge I_clk);
        // ready is back in the cycle after the previous response
        if (!cpu_ready) begin
            fail_run({"cache not ready before ", row_name[r]});
        end
        cpu_op    <= row_op[r];
        cpu_addr  <= row_addr[r];
        cpu_wdata <= row_wdata[r];
        cpu_wstrb <= row_strb[r];
        waited = 0;
        do begin
            @(posedge I_clk);
            waited++;
            if (waited > RESP_LIMIT) begin
                fail_run({"cache never became ready for ", row_name[r]});
            end
        end while (!cpu_ready);
        cpu_op <= OP_NONE;
        rd0    = rd_bursts;
        wb0    = wb_bursts;
        beats0 = wb_beats;
        lat    = 0;
        got    = 1'b0;
        while (!got) begin
            @(posedge I_clk);
            lat++;
            // ready stays low from acceptance through the response
            if (cpu_ready) begin
                fail_run({"cache raised ready before answering ", row_name[r]});
            end
            if (cpu_rvalid || cpu_bvalid) begin
                got = 1'b1;
            end else if (lat >= RESP_LIMIT) begin
                fail_run({"no response from the cache for ", row_name[r]});
            end
        end
        if (row_op[r] == OP_READ) begin
            if (!cpu_rvalid) begin
                fail_run({"write response returned for the read ", row_name[r]});
            end
            check_word(row_name[r], shadow[idx], cpu_rdata);
        end else begin
            if (!cpu_bvalid) begin
                fail_run({"read response returned for the write ", row_name[r]});
            end
            shadow[idx] = merge_bytes(shadow[idx], row_wdata[r], row_strb[r]);
        end
        check_count({row_name[r], " read bursts"}, row_reads[r], rd_bursts - rd0);
        check_count({row_name[r], " write bursts"}, row_wbs[r], wb_bursts - wb0);
        check_count({row_name[r], " write beats"}, row_wbs[r] * `DC_BEATS, wb_beats - beats0);
        if (row_reads[r] > 0) begin
            check_addr({row_name[r], " read address"}, row_addr[r] & ~32'h1f, last_araddr);
        end
        if (row_wbs[r] > 0) begin
            check_addr({row_name[r], " write address"}, row_wbaddr[r], last_awaddr);
        end
        // hits answer the cycle after acceptance
        if (row_reads[r] == 0) begin
            check_count({row_name[r], " latency"}, 1, lat);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_TIME);
        fail_run("watchdog expired before all table rows completed");
    end

    initial begin
        I_rst     = 1'b1;
        cpu_op    = OP_NONE;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        load_table();
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[mem_idx_t'(i)] = fill_pattern(addr_t'(i * `DC_WORD_BYTES));
        end
        repeat (8) @(posedge I_clk);
        I_rst <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Test passed");
        $finish;
    end

endmodule
